/* serializer_pkg.sv */
package serializer_pkg;

   // task field widths
   localparam int LOCALE_WIDTH  = 16;
   localparam int TTYPE_WIDTH   = 4;
   localparam int CQ_SLOT_WIDTH = 7;

   // a locale names the data a task touches
   typedef logic [LOCALE_WIDTH-1:0]  locale_t;
   typedef logic [TTYPE_WIDTH-1:0]   ttype_t;
   // slot in the commit queue that holds the task
   typedef logic [CQ_SLOT_WIDTH-1:0] cq_slot_t;

   // index of the lowest set bit, vectors of up to 32 bits
   // returns 0 when no bit is set, so callers qualify with a reduction or
   // by looking at the selected bit
   function automatic logic [4:0] lowest_set(input logic [31:0] vec);
      logic [4:0] idx;
      idx = '0;
      // scan from the top so the lowest hit is the last one written
      for (int i = 31; i >= 0; i--) begin
         if (vec[i]) begin
            idx = 5'(i);
         end
      end
      return idx;
   endfunction

endpackage

/* serializer_regs_pkg.sv */
package serializer_regs_pkg;

   // register bus widths
   localparam int REG_ADDR_WIDTH = 8;
   localparam int REG_DATA_WIDTH = 32;

   // threshold register, read and write
   localparam logic [REG_ADDR_WIDTH-1:0] ADDR_SIZE_CONTROL = 8'h10;
   // valid bits above conflict bits, read only
   localparam logic [REG_ADDR_WIDTH-1:0] ADDR_LIST_STATUS  = 8'h14;

   // threshold field positions inside ADDR_SIZE_CONTROL
   localparam int AF_LSB   = 0;
   localparam int FULL_LSB = 8;
   // each threshold field is one byte wide
   localparam int THRESH_WIDTH = 8;

endpackage

/* ready_list.sv */
`timescale 1ns/10ps

module ready_list import serializer_pkg::*; #(
   parameter int LOG_LIST_DEPTH = 3
) (
   input  logic                                clk,
   input  logic                                rstn,
   // enqueue side
   input  logic                                enq,
   input  logic                                enq_conflict,
   input  ttype_t                              m_ttype,
   input  locale_t                             m_locale,
   input  cq_slot_t                            m_cq_slot,
   // dequeue side
   input  logic                                s_ready,
   input  logic                                has_thread,
   input  logic                                any_running,
   // unlock of a finishing thread
   input  logic                                unlock_valid,
   input  locale_t                             finished_locale,
   output logic    [2**LOG_LIST_DEPTH-1:0]     entry_valid,
   output logic    [2**LOG_LIST_DEPTH-1:0]     entry_conflict,
   output locale_t [2**LOG_LIST_DEPTH-1:0]     entry_locale,
   output logic                                has_space,
   output logic                                s_valid,
   output logic                                issue,
   output logic                                all_cores_idle,
   output ttype_t                              s_ttype,
   output locale_t                             s_locale,
   output cq_slot_t                            s_cq_slot
);

   localparam int DEPTH = 2**LOG_LIST_DEPTH;

   // payload of each entry, entry 0 is the oldest
   ttype_t   [DEPTH-1:0] list_ttype;
   cq_slot_t [DEPTH-1:0] list_cq_slot;

   // neighbour above, used when the list shifts down
   ttype_t   [DEPTH-1:0] ttype_up;
   locale_t  [DEPTH-1:0] locale_up;
   cq_slot_t [DEPTH-1:0] cq_slot_up;
   logic     [DEPTH-1:0] valid_up;
   logic     [DEPTH-1:0] conflict_up;

   logic [DEPTH-1:0] ready_vec;
   logic [DEPTH-1:0] match;
   logic [DEPTH-1:0] clr;
   logic [DEPTH-1:0] kept;
   logic [DEPTH-1:0] shift;
   logic [DEPTH-1:0] load_new;
   logic [LOG_LIST_DEPTH-1:0] sel;
   logic [LOG_LIST_DEPTH-1:0] ins;
   logic [LOG_LIST_DEPTH-1:0] match_sel;

   // valid and not blocked by a running or older task
   assign ready_vec = entry_valid & ~entry_conflict;
   assign sel = LOG_LIST_DEPTH'(lowest_set(32'(ready_vec)));
   // list is kept packed from entry 0, first hole is the insert point
   assign ins = LOG_LIST_DEPTH'(lowest_set(32'(~entry_valid)));
   assign has_space = !entry_valid[ins];

   assign s_valid = (|ready_vec) & has_thread;
   assign issue   = s_valid & s_ready;
   assign s_ttype   = list_ttype[sel];
   assign s_locale  = entry_locale[sel];
   assign s_cq_slot = list_cq_slot[sel];

   assign all_cores_idle = !(|entry_valid) & !any_running;

   // earliest queued task with the finishing locale loses its conflict
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         match[i] = unlock_valid & entry_valid[i] & (entry_locale[i] == finished_locale);
      end
   end
   assign match_sel = LOG_LIST_DEPTH'(lowest_set(32'(match)));
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         clr[i] = match[i] & (match_sel == i);
      end
   end
   assign kept = entry_conflict & ~clr;

   // everything at or above the issued entry moves down one
   // a task arriving in the same cycle lands one below the hole
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         shift[i]    = issue && (i >= sel);
         load_new[i] = enq && (shift[i] ? (ins == i + 1) : (ins == i));
      end
   end

   // top entry takes zeros when shifting
   assign valid_up    = {1'b0, entry_valid[DEPTH-1:1]};
   assign conflict_up = {1'b0, kept[DEPTH-1:1]};
   assign ttype_up    = list_ttype >> TTYPE_WIDTH;
   assign locale_up   = entry_locale >> LOCALE_WIDTH;
   assign cq_slot_up  = list_cq_slot >> CQ_SLOT_WIDTH;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         entry_valid    <= '0;
         entry_conflict <= '0;
      end else begin
         for (int i = 0; i < DEPTH; i++) begin
            if (load_new[i]) begin
               entry_valid[i]    <= 1'b1;
               entry_conflict[i] <= enq_conflict;
            end else if (shift[i]) begin
               entry_valid[i]    <= valid_up[i];
               entry_conflict[i] <= conflict_up[i];
            end else begin
               entry_conflict[i] <= kept[i];
            end
         end
      end
   end

   // task payload
   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (load_new[i]) begin
            list_ttype[i]   <= m_ttype;
            entry_locale[i] <= m_locale;
            list_cq_slot[i] <= m_cq_slot;
         end else if (shift[i]) begin
            list_ttype[i]   <= ttype_up[i];
            entry_locale[i] <= locale_up[i];
            list_cq_slot[i] <= cq_slot_up[i];
         end
      end
   end

endmodule

/* locale_table.sv */
`timescale 1ns/10ps

module locale_table import serializer_pkg::*; #(
   parameter int N_THREADS      = 4,
   parameter int LOG_LIST_DEPTH = 3
) (
   input  logic                            clk,
   input  logic                            rstn,
   input  logic                            issue,
   input  logic    [$clog2(N_THREADS)-1:0] s_thread,
   input  locale_t                         s_locale,
   input  logic                            unlock_valid,
   input  logic    [$clog2(N_THREADS)-1:0] unlock_thread,
   input  locale_t                         m_locale,
   input  logic    [2**LOG_LIST_DEPTH-1:0] entry_valid,
   input  locale_t [2**LOG_LIST_DEPTH-1:0] entry_locale,
   output logic                            enq_conflict,
   output locale_t                         finished_locale,
   output logic                            any_running
);

   localparam int DEPTH = 2**LOG_LIST_DEPTH;

   // locale held by each running thread
   locale_t [N_THREADS-1:0] run_locale;
   logic    [N_THREADS-1:0] run_valid;
   logic    [N_THREADS-1:0] run_hit;
   logic    [DEPTH-1:0]     list_hit;

   assign finished_locale = run_locale[unlock_thread];
   assign any_running = |run_valid;

   // a thread unlocking this cycle no longer blocks the new task
   always_comb begin
      for (int j = 0; j < N_THREADS; j++) begin
         run_hit[j] = run_valid[j] & (run_locale[j] == m_locale) &
                      !(unlock_valid && (unlock_thread == j));
      end
      for (int i = 0; i < DEPTH; i++) begin
         list_hit[i] = entry_valid[i] & (entry_locale[i] == m_locale);
      end
   end
   assign enq_conflict = (|run_hit) | (|list_hit);

   // issued thread comes from the free list so it never equals the unlocked one
   always_ff @(posedge clk) begin
      if (!rstn) begin
         run_valid <= '0;
      end else begin
         for (int j = 0; j < N_THREADS; j++) begin
            if (issue && (s_thread == j)) begin
               run_valid[j] <= 1'b1;
            end else if (unlock_valid && (unlock_thread == j)) begin
               run_valid[j] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         run_locale[s_thread] <= s_locale;
      end
   end

endmodule

/* thread_free_list.sv */
`timescale 1ns/10ps

module thread_free_list #(
   parameter int N_THREADS = 4
) (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         unlock_valid,
   input  logic [$clog2(N_THREADS)-1:0] unlock_thread,
   input  logic                         issue,
   output logic [$clog2(N_THREADS)-1:0] s_thread,
   output logic                         has_thread
);

   localparam int TW = $clog2(N_THREADS);

   // ring of free thread numbers
   logic [TW-1:0] slots [N_THREADS];
   logic [TW-1:0] head;
   logic [TW-1:0] tail;
   logic [TW:0]   count;

   assign s_thread   = slots[head];
   assign has_thread = (count != '0);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         // every thread starts free, in ascending order
         for (int i = 0; i < N_THREADS; i++) begin
            slots[i] <= TW'(i);
         end
         head  <= '0;
         tail  <= '0;
         count <= (TW+1)'(N_THREADS);
      end else begin
         // pop at issue
         if (issue) begin
            head <= (head == TW'(N_THREADS - 1)) ? '0 : head + 1'b1;
         end
         // push back at unlock
         if (unlock_valid) begin
            slots[tail] <= unlock_thread;
            tail <= (tail == TW'(N_THREADS - 1)) ? '0 : tail + 1'b1;
         end
         count <= count + (TW+1)'(unlock_valid) - (TW+1)'(issue);
      end
   end

endmodule

/* occupancy_ctrl.sv */
`timescale 1ns/10ps

module occupancy_ctrl import serializer_regs_pkg::*; #(
   parameter int LOG_LIST_DEPTH = 3
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          m_valid,
   input  logic                          has_space,
   input  logic                          issue,
   input  logic [2**LOG_LIST_DEPTH-1:0]  entry_valid,
   input  logic [2**LOG_LIST_DEPTH-1:0]  entry_conflict,
   input  logic                          reg_wvalid,
   input  logic [REG_ADDR_WIDTH-1:0]     reg_waddr,
   input  logic [REG_DATA_WIDTH-1:0]     reg_wdata,
   input  logic                          reg_arvalid,
   input  logic [REG_ADDR_WIDTH-1:0]     reg_araddr,
   output logic                          m_ready,
   output logic                          almost_full,
   output logic                          reg_rvalid,
   output logic [REG_DATA_WIDTH-1:0]     reg_rdata
);

   localparam int DEPTH = 2**LOG_LIST_DEPTH;

   logic [LOG_LIST_DEPTH:0] count;
   logic [THRESH_WIDTH-1:0] count_ext;
   logic [THRESH_WIDTH-1:0] af_thresh;
   logic [THRESH_WIDTH-1:0] full_thresh;
   logic                    below_full;

   assign count_ext   = THRESH_WIDTH'(count);
   assign below_full  = (count_ext <= full_thresh);
   assign almost_full = (count_ext >= af_thresh);
   // accept only with a hole in the list and below the programmed limit
   assign m_ready = m_valid & has_space & below_full;

   // one in at accept, one out at issue
   always_ff @(posedge clk) begin
      if (!rstn) begin
         count <= '0;
      end else begin
         count <= count + (LOG_LIST_DEPTH+1)'(m_ready) - (LOG_LIST_DEPTH+1)'(issue);
      end
   end

   // thresholds, new values apply from the next cycle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         af_thresh   <= THRESH_WIDTH'(DEPTH - 4);
         full_thresh <= THRESH_WIDTH'(DEPTH - 1);
      end else if (reg_wvalid && (reg_waddr == ADDR_SIZE_CONTROL)) begin
         af_thresh   <= reg_wdata[AF_LSB +: THRESH_WIDTH];
         full_thresh <= reg_wdata[FULL_LSB +: THRESH_WIDTH];
      end
   end

   // read answers one cycle after the request
   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_arvalid) begin
         case (reg_araddr)
            ADDR_SIZE_CONTROL: reg_rdata <= REG_DATA_WIDTH'({full_thresh, af_thresh});
            ADDR_LIST_STATUS:  reg_rdata <= REG_DATA_WIDTH'({entry_valid, entry_conflict});
            default:           reg_rdata <= '0;
         endcase
      end
   end

endmodule

/* conflict_serializer.sv */
`timescale 1ns/10ps

module conflict_serializer import serializer_pkg::*, serializer_regs_pkg::*; #(
   parameter int LOG_LIST_DEPTH = 3,
   parameter int N_THREADS      = 4
) (
   input  logic                         clk,
   input  logic                         rstn,
   // from the commit queue
   input  logic                         m_valid,
   output logic                         m_ready,
   input  ttype_t                       m_ttype,
   input  locale_t                      m_locale,
   input  cq_slot_t                     m_cq_slot,
   // to the cores
   output logic                         s_valid,
   input  logic                         s_ready,
   output ttype_t                       s_ttype,
   output locale_t                      s_locale,
   output cq_slot_t                     s_cq_slot,
   output logic [$clog2(N_THREADS)-1:0] s_thread,
   // thread finished
   input  logic                         unlock_valid,
   input  logic [$clog2(N_THREADS)-1:0] unlock_thread,
   output logic                         almost_full,
   // high when nothing is queued or running, for termination
   output logic                         all_cores_idle,
   // register bus
   input  logic                         reg_wvalid,
   input  logic [REG_ADDR_WIDTH-1:0]    reg_waddr,
   input  logic [REG_DATA_WIDTH-1:0]    reg_wdata,
   input  logic                         reg_arvalid,
   input  logic [REG_ADDR_WIDTH-1:0]    reg_araddr,
   output logic                         reg_rvalid,
   output logic [REG_DATA_WIDTH-1:0]    reg_rdata
);

   localparam int DEPTH = 2**LOG_LIST_DEPTH;

   logic                 enq_conflict;
   locale_t              finished_locale;
   logic                 any_running;
   logic                 has_space;
   logic                 has_thread;
   logic                 issue;
   logic    [DEPTH-1:0]  entry_valid;
   logic    [DEPTH-1:0]  entry_conflict;
   locale_t [DEPTH-1:0]  entry_locale;

   // m_ready doubles as the enqueue strobe
   ready_list #(.LOG_LIST_DEPTH(LOG_LIST_DEPTH)) u_list (
      .clk, .rstn, .enq(m_ready), .enq_conflict, .m_ttype, .m_locale, .m_cq_slot,
      .s_ready, .has_thread, .any_running, .unlock_valid, .finished_locale,
      .entry_valid, .entry_conflict, .entry_locale, .has_space, .s_valid, .issue,
      .all_cores_idle, .s_ttype, .s_locale, .s_cq_slot
   );

   locale_table #(.N_THREADS(N_THREADS), .LOG_LIST_DEPTH(LOG_LIST_DEPTH)) u_locales (
      .clk, .rstn, .issue, .s_thread, .s_locale, .unlock_valid, .unlock_thread,
      .m_locale, .entry_valid, .entry_locale, .enq_conflict, .finished_locale,
      .any_running
   );

   thread_free_list #(.N_THREADS(N_THREADS)) u_threads (
      .clk, .rstn, .unlock_valid, .unlock_thread, .issue, .s_thread, .has_thread
   );

   occupancy_ctrl #(.LOG_LIST_DEPTH(LOG_LIST_DEPTH)) u_occupancy (
      .clk, .rstn, .m_valid, .has_space, .issue, .entry_valid, .entry_conflict,
      .reg_wvalid, .reg_waddr, .reg_wdata, .reg_arvalid, .reg_araddr,
      .m_ready, .almost_full, .reg_rvalid, .reg_rdata
   );

endmodule

/* conflict_serializer_asserts.sv */
`timescale 1ns/10ps

module conflict_serializer_asserts (
   input logic clk,
   input logic rstn,
   input logic m_valid,
   input logic m_ready,
   input logic s_valid,
   input logic all_cores_idle,
   input logic reg_arvalid,
   input logic reg_rvalid
);

   // latches high once any property fails
   bit any_failed = 1'b0;

   // producer side only answers a pending request
   ready_needs_valid: assert property (@(posedge clk) disable iff (!rstn) m_ready |-> m_valid)
      else begin
         $error("m_ready high while m_valid is low");
         any_failed = 1'b1;
      end

   // read response is exactly one cycle behind the request
   rvalid_follows_arvalid: assert property (@(posedge clk) disable iff (!rstn)
      reg_rvalid == $past(reg_arvalid))
      else begin
         $error("reg_rvalid does not follow reg_arvalid by one cycle");
         any_failed = 1'b1;
      end

   // an offered task means the list is not empty
   offer_not_idle: assert property (@(posedge clk) disable iff (!rstn)
      s_valid |-> !all_cores_idle)
      else begin
         $error("s_valid high while all_cores_idle is high");
         any_failed = 1'b1;
      end

endmodule

bind conflict_serializer conflict_serializer_asserts u_asserts (.*);

/* tb_conflict_serializer.sv */
`timescale 1ns/10ps

module tb_conflict_serializer import serializer_pkg::*, serializer_regs_pkg::*; ();

   localparam int LOG_LIST_DEPTH = 3;
   localparam int N_THREADS      = 4;
   localparam int DEPTH          = 2**LOG_LIST_DEPTH;
   localparam int RESET_CYCLES   = 10;
   localparam int RANDOM_CYCLES  = 2000;
   localparam int DRAIN_LIMIT    = 200;
   // reset, traffic, drain and some slack
   localparam int TOTAL_CYCLES   = RESET_CYCLES + RANDOM_CYCLES + DRAIN_LIMIT + 50;

   logic                         clk;
   logic                         rstn;
   logic                         m_valid;
   logic                         m_ready;
   ttype_t                       m_ttype;
   locale_t                      m_locale;
   cq_slot_t                     m_cq_slot;
   logic                         s_valid;
   logic                         s_ready;
   ttype_t                       s_ttype;
   locale_t                      s_locale;
   cq_slot_t                     s_cq_slot;
   logic [$clog2(N_THREADS)-1:0] s_thread;
   logic                         unlock_valid;
   logic [$clog2(N_THREADS)-1:0] unlock_thread;
   logic                         almost_full;
   logic                         all_cores_idle;
   logic                         reg_wvalid;
   logic [REG_ADDR_WIDTH-1:0]    reg_waddr;
   logic [REG_DATA_WIDTH-1:0]    reg_wdata;
   logic                         reg_arvalid;
   logic [REG_ADDR_WIDTH-1:0]    reg_araddr;
   logic                         reg_rvalid;
   logic [REG_DATA_WIDTH-1:0]    reg_rdata;

   // reference model
   // list index 0 is the oldest task
   int          q_locale[$];
   int          q_ttype[$];
   int          q_slot[$];
   bit          q_conflict[$];
   int          free_threads[$];
   bit          run_valid [N_THREADS];
   int          run_locale [N_THREADS];
   int          count;
   int          af_thresh;
   int          full_thresh;
   bit          rd_pending;
   logic [31:0] rd_expected;

   conflict_serializer #(.LOG_LIST_DEPTH(LOG_LIST_DEPTH), .N_THREADS(N_THREADS)) uut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic stop_run();
      $display(">>> FAIL");
      $fatal(1);
   endtask

   initial begin
      #(TOTAL_CYCLES * 20);
      $display("timeout: the run did not finish within %0d cycles", TOTAL_CYCLES);
      stop_run();
   end

   // a failing bound property ends the run
   initial begin
      wait (uut.u_asserts.any_failed);
      $display("a bound assertion on the DUT failed");
      stop_run();
   end

   task automatic check_value(input string test, input string name,
                              input logic [31:0] expected, input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("ERROR %s: %s expected 0x%0h actual 0x%0h", test, name, expected, actual);
         stop_run();
      end
   endtask

   function automatic bit model_idle();
      bit idle;
      idle = (q_locale.size() == 0);
      for (int j = 0; j < N_THREADS; j++) begin
         idle = idle && !run_valid[j];
      end
      return idle;
   endfunction

   function automatic logic [REG_ADDR_WIDTH-1:0] pick_read_addr();
      case ($urandom_range(2))
         0:       return ADDR_SIZE_CONTROL;
         1:       return ADDR_LIST_STATUS;
         default: return 8'h3c;
      endcase
   endfunction

   // compare with the model and then step the model over the coming edge
   task automatic check_and_advance(input string test);
      int          sel;
      int          thread;
      int          fin;
      bit          exp_s_valid;
      bit          exp_m_ready;
      bit          conflict;
      logic [31:0] status;
      sel = -1;
      // scan down so the oldest ready entry wins
      for (int i = q_locale.size() - 1; i >= 0; i--) begin
         if (!q_conflict[i]) begin
            sel = i;
         end
      end
      exp_s_valid = (sel >= 0) && (free_threads.size() > 0);
      exp_m_ready = m_valid && (q_locale.size() < DEPTH) && (count <= full_thresh);
      check_value(test, "s_valid", exp_s_valid, s_valid);
      if (exp_s_valid) begin
         check_value(test, "s_ttype", q_ttype[sel], s_ttype);
         check_value(test, "s_locale", q_locale[sel], s_locale);
         check_value(test, "s_cq_slot", q_slot[sel], s_cq_slot);
         check_value(test, "s_thread", free_threads[0], s_thread);
      end
      check_value(test, "m_ready", exp_m_ready, m_ready);
      check_value(test, "almost_full", count >= af_thresh, almost_full);
      check_value(test, "all_cores_idle", model_idle(), all_cores_idle);
      check_value(test, "reg_rvalid", rd_pending, reg_rvalid);
      if (rd_pending) begin
         check_value(test, "reg_rdata", rd_expected, reg_rdata);
      end

      // read data is taken from the state before the edge
      rd_pending = reg_arvalid;
      status = '0;
      for (int i = 0; i < q_locale.size(); i++) begin
         status[DEPTH + i] = 1'b1;
         status[i] = q_conflict[i];
      end
      if (reg_araddr == ADDR_SIZE_CONTROL) begin
         rd_expected = {16'h0, 8'(full_thresh), 8'(af_thresh)};
      end else if (reg_araddr == ADDR_LIST_STATUS) begin
         rd_expected = status;
      end else begin
         rd_expected = '0;
      end

      // new task conflicts with any queued task or any thread that keeps running
      conflict = 1'b0;
      foreach (q_locale[i]) begin
         conflict = conflict || (q_locale[i] == m_locale);
      end
      for (int j = 0; j < N_THREADS; j++) begin
         if (run_valid[j] && run_locale[j] == m_locale && !(unlock_valid && unlock_thread == j)) begin
            conflict = 1'b1;
         end
      end

      // finishing thread releases the earliest queued task with its locale
      if (unlock_valid) begin
         fin = run_locale[unlock_thread];
         for (int i = 0; i < q_locale.size(); i++) begin
            if (q_locale[i] == fin) begin
               q_conflict[i] = 1'b0;
               break;
            end
         end
         run_valid[unlock_thread] = 1'b0;
      end

      if (exp_s_valid && s_ready) begin
         thread = free_threads.pop_front();
         for (int j = 0; j < N_THREADS; j++) begin
            assert (!(run_valid[j] && run_locale[j] == s_locale)) else begin
               $display("two running threads would share locale 0x%0h", s_locale);
               stop_run();
            end
         end
         run_valid[thread] = 1'b1;
         run_locale[thread] = q_locale[sel];
         q_locale.delete(sel);
         q_ttype.delete(sel);
         q_slot.delete(sel);
         q_conflict.delete(sel);
         count--;
      end
      if (unlock_valid) begin
         free_threads.push_back(unlock_thread);
      end

      // accepted task goes behind the last queued one
      if (exp_m_ready) begin
         q_locale.push_back(m_locale);
         q_ttype.push_back(m_ttype);
         q_slot.push_back(m_cq_slot);
         q_conflict.push_back(conflict);
         count++;
      end
      if (reg_wvalid && reg_waddr == ADDR_SIZE_CONTROL) begin
         af_thresh = reg_wdata[AF_LSB +: 8];
         full_thresh = reg_wdata[FULL_LSB +: 8];
      end
   endtask

   // with traffic off the list drains with no new tasks
   // cores are then always ready and one thread unlocks every cycle
   task automatic drive_cycle(input int cyc, input bit traffic);
      int running[$];
      for (int j = 0; j < N_THREADS; j++) begin
         if (run_valid[j]) begin
            running.push_back(j);
         end
      end
      m_valid   <= traffic && ($urandom_range(99) < 60);
      s_ready   <= !traffic || ($urandom_range(99) < 50);
      m_ttype   <= ttype_t'($urandom);
      // four locales keep conflicts frequent
      m_locale  <= locale_t'(16'h0a10 + $urandom_range(3));
      m_cq_slot <= cq_slot_t'($urandom);
      if (running.size() > 0 && (!traffic || $urandom_range(99) < 30)) begin
         unlock_valid  <= 1'b1;
         unlock_thread <= running[$urandom_range(running.size() - 1)];
      end else begin
         unlock_valid <= 1'b0;
      end
      if (traffic && cyc == RANDOM_CYCLES / 2) begin
         reg_wvalid  <= 1'b1;
         reg_waddr   <= ADDR_SIZE_CONTROL;
         reg_wdata   <= {16'h0, 8'($urandom_range(8, 2)), 8'($urandom_range(8))};
         reg_arvalid <= 1'b0;
      end else if (traffic && cyc == RANDOM_CYCLES / 2 + 1) begin
         // read back what was just written
         reg_wvalid  <= 1'b0;
         reg_arvalid <= 1'b1;
         reg_araddr  <= ADDR_SIZE_CONTROL;
      end else begin
         reg_wvalid  <= 1'b0;
         reg_arvalid <= ($urandom_range(99) < 10);
         reg_araddr  <= pick_read_addr();
      end
   endtask

   initial begin
      void'($urandom(79444));
      rstn = 1'b0;
      m_valid = 1'b0;
      m_ttype = '0;
      m_locale = '0;
      m_cq_slot = '0;
      s_ready = 1'b0;
      unlock_valid = 1'b0;
      unlock_thread = '0;
      reg_wvalid = 1'b0;
      reg_waddr = '0;
      reg_wdata = '0;
      reg_arvalid = 1'b0;
      reg_araddr = '0;
      count = 0;
      af_thresh = DEPTH - 4;
      full_thresh = DEPTH - 1;
      rd_pending = 1'b0;
      for (int j = 0; j < N_THREADS; j++) begin
         free_threads.push_back(j);
         run_valid[j] = 1'b0;
      end

      repeat (RESET_CYCLES - 1) @(posedge clk);
      @(negedge clk);
      check_value("reset", "s_valid", 0, s_valid);
      check_value("reset", "m_ready", 0, m_ready);
      check_value("reset", "almost_full", 0, almost_full);
      check_value("reset", "reg_rvalid", 0, reg_rvalid);
      check_value("reset", "all_cores_idle", 1, all_cores_idle);
      @(posedge clk);
      rstn <= 1'b1;

      for (int cyc = 0; cyc < RANDOM_CYCLES; cyc++) begin
         @(posedge clk);
         drive_cycle(cyc, 1'b1);
         @(negedge clk);
         check_and_advance("random");
      end

      // watchdog bounds this loop
      while (!model_idle()) begin
         @(posedge clk);
         drive_cycle(0, 1'b0);
         @(negedge clk);
         check_and_advance("drain");
      end
      @(posedge clk);
      drive_cycle(0, 1'b0);
      @(negedge clk);
      check_and_advance("drain");
      check_value("drain", "all_cores_idle", 1, all_cores_idle);

      $display(">>> PASS");
      $finish;
   end

endmodule

/* vlog.f */
serializer_pkg.sv
serializer_regs_pkg.sv
ready_list.sv
locale_table.sv
thread_free_list.sv
occupancy_ctrl.sv
conflict_serializer.sv
conflict_serializer_asserts.sv
tb_conflict_serializer.sv

/* Bender.yml */
package:
  name: conflict_serializer

sources:
  - serializer_pkg.sv
  - serializer_regs_pkg.sv
  - ready_list.sv
  - locale_table.sv
  - thread_free_list.sv
  - occupancy_ctrl.sv
  - conflict_serializer.sv
  - target: simulation
    files:
      - conflict_serializer_asserts.sv
      - tb_conflict_serializer.sv
